// ==== Makefile ====
# Verilator build and run for the winner screen overlay

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing --assert
TOP       ?= win_screen_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
PASS_MSG  ?= TB PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

# The run passes only when the pass message shows up in the output
run: build
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -F "$(PASS_MSG)" > /dev/null

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)

// ==== design/rect_set_match.sv ====
// Rectangle set matcher
// Tests one pixel position against every rectangle of a layer
// and flags a hit in the same cycle

`timescale 1ns/1ps

module rect_set_match #(
    parameter screen_pkg::layer_t LAYER = screen_pkg::LAYER_HEADLINE
) (
    input  vga_pkg::coord_t hcount,
    input  vga_pkg::coord_t vcount,
    output logic            hit
);

    import screen_pkg::*;

    localparam int COUNT = (LAYER == LAYER_HEADLINE) ? HEADLINE_COUNT :
                           (LAYER == LAYER_BUTTON)   ? BUTTON_COUNT : CAPTION_COUNT;

    function automatic rect_t pick(input int idx);
        case (LAYER)
            LAYER_HEADLINE: return HEADLINE_RECTS[idx];
            LAYER_BUTTON:   return BUTTON_RECTS[idx];
            default:        return CAPTION_RECTS[idx];
        endcase
    endfunction

    logic [COUNT-1:0] hits;

    // One comparator set per table entry
    for (genvar i = 0; i < COUNT; i++) begin : g_rect
        localparam rect_t R = pick(i);
        assign hits[i] = (hcount > R.x_lo) && (hcount < R.x_hi) &&
                         (vcount > R.y_lo) && (vcount < R.y_hi);
    end

    assign hit = |hits;

endmodule

// ==== design/screen_pkg.sv ====
// Winner screen layout
// Player and layer selectors, the rectangle type and the rectangle
// tables that spell out the headline, the button and its caption

package screen_pkg;

    import vga_pkg::*;

    typedef enum logic {
        PLAYER_1 = 1'b0,
        PLAYER_2 = 1'b1
    } player_t;

    typedef enum logic [1:0] {
        LAYER_HEADLINE = 2'd0,
        LAYER_BUTTON   = 2'd1,
        LAYER_CAPTION  = 2'd2
    } layer_t;

    // Both bounds exclusive on each axis
    typedef struct packed {
        coord_t x_lo;
        coord_t x_hi;
        coord_t y_lo;
        coord_t y_hi;
    } rect_t;

    function automatic rect_t make_rect(input int x_lo, input int x_hi,
                                        input int y_lo, input int y_hi);
        return '{x_lo: coord_t'(x_lo), x_hi: coord_t'(x_hi),
                 y_lo: coord_t'(y_lo), y_hi: coord_t'(y_hi)};
    endfunction

    localparam int HEADLINE_COUNT = 46;
    localparam int BUTTON_COUNT = 4;
    localparam int CAPTION_COUNT = 34;

    // "WINS" on the lower line, "PLAYER" above it
    localparam rect_t HEADLINE_RECTS [HEADLINE_COUNT] = '{
        // W
        make_rect(417, 427, 330, 410),
        make_rect(427, 437, 390, 400),
        make_rect(437, 447, 380, 390),
        make_rect(447, 457, 390, 400),
        make_rect(457, 467, 330, 410),
        // I
        make_rect(477, 487, 330, 410),
        // N
        make_rect(497, 507, 330, 410),
        make_rect(507, 517, 340, 360),
        make_rect(517, 527, 360, 380),
        make_rect(527, 537, 380, 400),
        make_rect(537, 547, 330, 410),
        // S
        make_rect(567, 597, 330, 340),
        make_rect(557, 567, 340, 360),
        make_rect(567, 597, 360, 370),
        make_rect(597, 607, 370, 400),
        make_rect(567, 597, 400, 410),
        make_rect(557, 567, 390, 400),
        // P
        make_rect(307, 317, 170, 290),
        make_rect(307, 337, 170, 185),
        make_rect(337, 347, 185, 200),
        make_rect(347, 357, 200, 230),
        make_rect(337, 347, 230, 245),
        make_rect(307, 337, 245, 260),
        // L
        make_rect(367, 377, 170, 290),
        make_rect(367, 417, 275, 290),
        // A
        make_rect(427, 437, 185, 290),
        make_rect(467, 477, 185, 290),
        make_rect(437, 467, 170, 185),
        make_rect(427, 477, 230, 245),
        // Y
        make_rect(487, 497, 170, 215),
        make_rect(527, 537, 170, 215),
        make_rect(497, 507, 215, 230),
        make_rect(517, 527, 215, 230),
        make_rect(507, 517, 230, 290),
        // E
        make_rect(547, 557, 170, 290),
        make_rect(547, 597, 170, 185),
        make_rect(547, 597, 275, 290),
        make_rect(547, 587, 222, 237),
        // R
        make_rect(607, 617, 170, 290),
        make_rect(607, 637, 170, 185),
        make_rect(637, 647, 185, 200),
        make_rect(647, 657, 200, 230),
        make_rect(637, 647, 230, 245),
        make_rect(607, 637, 245, 260),
        make_rect(637, 647, 260, 275),
        make_rect(647, 657, 275, 290)
    };

    // Top, left, right and bottom bars
    localparam rect_t BUTTON_RECTS [BUTTON_COUNT] = '{
        make_rect(237, 787, 430, 435),
        make_rect(237, 242, 430, 530),
        make_rect(782, 787, 430, 530),
        make_rect(237, 787, 525, 530)
    };

    // "PLAY AGAIN" inside the button
    localparam rect_t CAPTION_RECTS [CAPTION_COUNT] = '{
        // P
        make_rect(287, 297, 450, 510),
        make_rect(287, 317, 450, 460),
        make_rect(317, 327, 460, 480),
        make_rect(287, 317, 480, 490),
        // L
        make_rect(337, 347, 450, 510),
        make_rect(337, 377, 500, 510),
        // A
        make_rect(387, 397, 460, 510),
        make_rect(417, 427, 460, 510),
        make_rect(397, 417, 450, 460),
        make_rect(387, 427, 480, 490),
        // Y
        make_rect(437, 447, 450, 470),
        make_rect(447, 457, 470, 480),
        make_rect(457, 467, 480, 510),
        make_rect(467, 477, 470, 480),
        make_rect(477, 487, 450, 470),
        // A
        make_rect(517, 527, 460, 510),
        make_rect(547, 557, 460, 510),
        make_rect(527, 547, 450, 460),
        make_rect(517, 557, 480, 490),
        // G
        make_rect(567, 577, 450, 510),
        make_rect(567, 607, 450, 460),
        make_rect(567, 607, 500, 510),
        make_rect(597, 607, 480, 510),
        make_rect(587, 607, 480, 490),
        // A
        make_rect(617, 627, 460, 510),
        make_rect(647, 657, 460, 510),
        make_rect(627, 647, 450, 460),
        make_rect(617, 657, 480, 490),
        // I
        make_rect(667, 677, 450, 510),
        // N
        make_rect(687, 697, 450, 510),
        make_rect(727, 737, 450, 510),
        make_rect(697, 707, 460, 470),
        make_rect(707, 717, 470, 490),
        make_rect(717, 727, 490, 500)
    };

endpackage

// ==== design/vga_pkg.sv ====
// VGA stream types
// Pixel counters, 4-4-4 colour and the timing/pixel bundles
// that travel one pixel per clock

`include "win_screen_defs.svh"

package vga_pkg;

    typedef logic [`COORD_W-1:0] coord_t;
    typedef logic [`RGB_W-1:0] rgb_t;

    // Sync and blanking travel with the counters
    typedef struct packed {
        coord_t hcount;
        coord_t vcount;
        logic   hsync;
        logic   vsync;
        logic   hblnk;
        logic   vblnk;
    } vga_timing_t;

    typedef struct packed {
        vga_timing_t timing;
        rgb_t        rgb;
    } vga_pixel_t;

endpackage

// ==== design/win_screen_ctrl.sv ====
// Winner screen colour control
// Draws the visible-area frame, resolves the layer priority with the
// winner and loser colours and registers the pixel for one cycle

`timescale 1ns/1ps

`include "win_screen_defs.svh"

module win_screen_ctrl (
    input  logic                clk,
    input  logic                rst,
    input  vga_pkg::vga_pixel_t pix_in,
    input  screen_pkg::player_t winner,
    input  logic                headline_hit,
    input  logic                button_hit,
    input  logic                caption_hit,
    output vga_pkg::vga_pixel_t pix_out
);

    import vga_pkg::*;
    import screen_pkg::*;

    rgb_t win_rgb;
    rgb_t lose_rgb;
    rgb_t rgb_nxt;
    logic blank;
    logic on_frame;

    // Loser colour goes to the caption
    assign win_rgb  = (winner == PLAYER_1) ? `PLAYER1_COLOR : `PLAYER2_COLOR;
    assign lose_rgb = (winner == PLAYER_1) ? `PLAYER2_COLOR : `PLAYER1_COLOR;

    assign blank = pix_in.timing.hblnk || pix_in.timing.vblnk;

    // One pixel border of the visible area
    assign on_frame = (pix_in.timing.vcount == '0) ||
                      (pix_in.timing.vcount == coord_t'(`VER_PIXELS - 1)) ||
                      (pix_in.timing.hcount == '0) ||
                      (pix_in.timing.hcount == coord_t'(`HOR_PIXELS - 1));

    always_comb begin
        if (blank) begin
            rgb_nxt = `BLANK_COLOR;
        end else if (on_frame) begin
            rgb_nxt = win_rgb;
        end else if (headline_hit) begin
            rgb_nxt = win_rgb;
        end else if (button_hit) begin
            rgb_nxt = `BUTTON_COLOR;
        end else if (caption_hit) begin
            rgb_nxt = lose_rgb;
        end else begin
            rgb_nxt = pix_in.rgb;
        end
    end

    // Timing passes through unchanged and one clock late
    always_ff @(posedge clk) begin
        if (rst) begin
            pix_out <= '0;
        end else begin
            pix_out.timing <= pix_in.timing;
            pix_out.rgb    <= rgb_nxt;
        end
    end

endmodule

// ==== design/win_screen_defs.svh ====
// Winner screen constants
// Visible area size, field widths and the fixed colours of the overlay

`ifndef WIN_SCREEN_DEFS_SVH
`define WIN_SCREEN_DEFS_SVH

// Visible area
`define HOR_PIXELS 1024
`define VER_PIXELS 768

// Field widths
`define COORD_W 11
`define RGB_W 12

// Player colours in 4-4-4
`define PLAYER1_COLOR 12'hf00
`define PLAYER2_COLOR 12'h0f0

// Button outline
`define BUTTON_COLOR 12'h00f

// Blanking output
`define BLANK_COLOR 12'h000

`endif

// ==== design/win_screen_overlay.sv ====
// Winner screen overlay
// Frame, headline, button and caption drawn over a VGA stream
// with one clock of latency

`timescale 1ns/1ps

module win_screen_overlay (
    input  logic                clk,
    input  logic                rst,
    input  vga_pkg::vga_pixel_t pix_in,
    input  screen_pkg::player_t winner,
    output vga_pkg::vga_pixel_t pix_out
);

    import screen_pkg::*;

    logic headline_hit;
    logic button_hit;
    logic caption_hit;

    rect_set_match #(.LAYER(LAYER_HEADLINE)) u_headline_match (
        .hcount (pix_in.timing.hcount),
        .vcount (pix_in.timing.vcount),
        .hit    (headline_hit)
    );

    rect_set_match #(.LAYER(LAYER_BUTTON)) u_button_match (
        .hcount (pix_in.timing.hcount),
        .vcount (pix_in.timing.vcount),
        .hit    (button_hit)
    );

    rect_set_match #(.LAYER(LAYER_CAPTION)) u_caption_match (
        .hcount (pix_in.timing.hcount),
        .vcount (pix_in.timing.vcount),
        .hit    (caption_hit)
    );

    win_screen_ctrl u_ctrl (
        .clk          (clk),
        .rst          (rst),
        .pix_in       (pix_in),
        .winner       (winner),
        .headline_hit (headline_hit),
        .button_hit   (button_hit),
        .caption_hit  (caption_hit),
        .pix_out      (pix_out)
    );

endmodule

// ==== src.f ====
+incdir+design
design/vga_pkg.sv
design/screen_pkg.sv
design/rect_set_match.sv
design/win_screen_ctrl.sv
design/win_screen_overlay.sv
tb/win_screen_assert.sv
tb/win_screen_tb.sv

// ==== tb/win_screen_assert.sv ====
// Winner screen overlay port checks
// Reset clearing, timing pass-through and black output during blanking

`timescale 1ns/1ps

`include "win_screen_defs.svh"

module win_screen_assert (
    input logic                clk,
    input logic                rst,
    input vga_pkg::vga_pixel_t pix_in,
    input vga_pkg::vga_pixel_t pix_out
);

    import vga_pkg::*;

    logic in_blank;

    assign in_blank = pix_in.timing.hblnk || pix_in.timing.vblnk;

    // Every field cleared including syncs and blanking flags
    reset_clears_output: assert property (
        @(posedge clk) rst |=> (pix_out == '0)
    ) else $error("pix_out not zero after reset");

    timing_passes_through: assert property (
        @(posedge clk) !rst |=> (pix_out.timing == $past(pix_in.timing))
    ) else $error("pix_out timing differs from last input timing");

    blank_is_black: assert property (
        @(posedge clk) (!rst && in_blank) |=> (pix_out.rgb == rgb_t'(`BLANK_COLOR))
    ) else $error("colour not black after a blanking input");

endmodule

bind win_screen_overlay win_screen_assert win_screen_assert_inst (
    .clk     (clk),
    .rst     (rst),
    .pix_in  (pix_in),
    .pix_out (pix_out)
);

// ==== tb/win_screen_tb.sv ====
// Winner screen overlay testbench
// Replays pixels from the vector file and compares each output pixel
// one clock later with its expected colour and timing

`timescale 1ns/1ps

module win_screen_tb;

    import vga_pkg::*;
    import screen_pkg::*;

    localparam int RESET_CYCLES = 10;
    localparam int SLACK_CYCLES = 20;
    localparam string VECTOR_FILE = "tb/win_screen_vectors.txt";

    typedef struct packed {
        vga_pixel_t pix;
        player_t    winner;
        rgb_t       exp_rgb;
    } vector_t;

    logic       clk;
    logic       rst;
    vga_pixel_t pix_in;
    player_t    winner;
    vga_pixel_t pix_out;

    vector_t vectors[$];
    int      cycle_count;
    int      cycle_limit;

    win_screen_overlay win_screen_overlay_inst (
        .clk     (clk),
        .rst     (rst),
        .pix_in  (pix_in),
        .winner  (winner),
        .pix_out (pix_out)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    task automatic stop_on_failure();
        $display("TB FAILED");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("CHECK FAILED at time %0t: %s (got %0h, expected %0h)",
                     $time, what, actual, expected);
            stop_on_failure();
        end
    endtask

    // One pixel per text line with # lines skipped
    task automatic load_vectors();
        int      fd;
        int      n;
        string   line;
        int      hb, vb, hs, vs, hc, vc, rgb_in, win, rgb_exp;
        vector_t v;
        fd = $fopen(VECTOR_FILE, "r");
        if (fd == 0) begin
            $display("Could not open the vector file %s", VECTOR_FILE);
            stop_on_failure();
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n == 0 || line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            n = $sscanf(line, "%d %d %d %d %d %d %h %d %h",
                        hb, vb, hs, vs, hc, vc, rgb_in, win, rgb_exp);
            if (n != 9) begin
                $display("Malformed line in the vector file: %s", line);
                stop_on_failure();
            end
            v.pix.timing.hblnk  = hb[0];
            v.pix.timing.vblnk  = vb[0];
            v.pix.timing.hsync  = hs[0];
            v.pix.timing.vsync  = vs[0];
            v.pix.timing.hcount = coord_t'(hc);
            v.pix.timing.vcount = coord_t'(vc);
            v.pix.rgb           = rgb_t'(rgb_in);
            v.winner            = player_t'(win[0]);
            v.exp_rgb           = rgb_t'(rgb_exp);
            vectors.push_back(v);
        end
        $fclose(fd);
        if (vectors.size() == 0) begin
            $display("The vector file holds no vectors");
            stop_on_failure();
        end
    endtask

    task automatic drive_vector(input vector_t v);
        pix_in = v.pix;
        winner = v.winner;
    endtask

    // Output of a vector shows up one clock after it was driven
    task automatic check_vector(input int idx);
        check_value(64'(pix_out.rgb), 64'(vectors[idx].exp_rgb),
                    $sformatf("vector %0d colour", idx));
        check_value(64'(pix_out.timing), 64'(vectors[idx].pix.timing),
                    $sformatf("vector %0d timing", idx));
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout after %0d cycles without finishing the vectors", cycle_count);
            stop_on_failure();
        end
    end

    initial begin
        cycle_count = 0;
        cycle_limit = RESET_CYCLES + SLACK_CYCLES;
        rst = 1'b1;
        winner = PLAYER_1;
        // Non-zero pixel during reset so the clearing is visible
        pix_in.timing.hcount = coord_t'(5);
        pix_in.timing.vcount = coord_t'(5);
        pix_in.timing.hsync = 1'b1;
        pix_in.timing.vsync = 1'b1;
        pix_in.timing.hblnk = 1'b1;
        pix_in.timing.vblnk = 1'b1;
        pix_in.rgb = rgb_t'(12'hfff);

        load_vectors();
        cycle_limit = RESET_CYCLES + vectors.size() + SLACK_CYCLES;

        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        check_value(64'(pix_out), 64'(0), "pix_out after reset");
        rst = 1'b0;
        drive_vector(vectors[0]);

        for (int i = 1; i <= vectors.size(); i++) begin
            @(posedge clk);
            #1;
            check_vector(i - 1);
            if (i < vectors.size()) begin
                drive_vector(vectors[i]);
            end
        end

        $display("TB PASSED");
        $finish;
    end

endmodule

// ==== tb/win_screen_vectors.txt ====
# hblnk vblnk hsync vsync hcount vcount rgb_in(hex) winner expected_rgb(hex)
# winner 0 is player 1 (f00), winner 1 is player 2 (0f0)
1 0 1 0 1100 100 abc 0 000
0 1 0 1 200 800 5a5 1 000
1 1 1 1 0 0 fff 0 000
0 0 0 0 500 0 123 0 f00
0 0 1 0 500 767 123 1 0f0
0 0 0 1 0 300 456 0 f00
0 0 0 0 1023 300 456 1 0f0
0 0 0 0 420 350 777 0 f00
0 0 0 0 420 350 777 1 0f0
0 0 0 0 610 200 777 0 f00
0 0 1 1 650 280 777 1 0f0
0 0 0 0 417 350 777 0 777
0 0 0 0 420 330 888 0 888
0 0 0 0 427 350 999 1 999
0 0 0 0 500 432 321 0 00f
0 0 0 0 240 480 321 1 00f
0 0 0 0 600 527 321 0 00f
0 0 0 0 785 500 321 1 00f
0 0 0 0 520 490 444 0 0f0
0 0 0 0 390 470 444 1 f00
0 0 0 0 690 480 444 0 0f0
0 0 0 0 710 480 444 1 f00
0 0 0 0 100 100 3c7 0 3c7
0 0 1 0 900 600 a5a 1 a5a
0 0 0 0 1 1 246 0 246
0 0 0 0 260 480 135 0 135
0 0 0 0 537 470 6e1 1 6e1
0 0 0 1 1022 766 0ff 1 0ff
